/* include/gf_math.svh */
`ifndef GF_MATH_SVH
`define GF_MATH_SVH

// product of two field elements, reduced by gf_poly
function automatic logic [gf_m-1:0] gf_mul(input logic [gf_m-1:0] a, input logic [gf_m-1:0] b);
	logic [gf_m-1:0] acc;
	logic [gf_m-1:0] sh;
	acc = '0;
	sh = a;
	for (int i = 0; i < gf_m; i++) begin
		if (b[i])
			acc = acc ^ sh; // add shifted copy
		if (sh[gf_m-1])
			sh = (sh << 1) ^ gf_poly[gf_m-1:0]; // reduce on overflow
		else
			sh = sh << 1;
	end
	return acc;
endfunction

function automatic logic [gf_m-1:0] gf_sq(input logic [gf_m-1:0] a);
	return gf_mul(a, a);
endfunction

// alpha^e by square and multiply, e taken mod gf_order
function automatic logic [gf_m-1:0] gf_alpha_pow(input int unsigned e);
	logic [gf_m-1:0] res;
	logic [gf_m-1:0] base;
	int unsigned k;
	res = 1;
	base = 2; // alpha
	k = e % gf_order;
	while (k != 0) begin
		if (k[0])
			res = gf_mul(res, base);
		base = gf_sq(base);
		k = k >> 1;
	end
	return res;
endfunction

`endif

/* source/gf_pkg.sv */
`default_nettype none

package gf_pkg;

	localparam int gf_m = 4; // symbol width
	localparam logic [gf_m:0] gf_poly = 5'b10011; // x^4 + x + 1
	localparam int gf_order = (1 << gf_m) - 1; // nonzero elements

	`include "gf_math.svh"

endpackage

`default_nettype wire

/* source/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	localparam int bch_n = 15; // code length
	localparam int bch_t = 3; // correctable errors
	localparam int bch_syn_cnt = 2 * bch_t;

	// key solver alternates discrepancy and update cycles
	typedef enum logic [1:0] {
		solver_idle,
		solver_disc,
		solver_update
	} solver_state_e;

	typedef enum logic {
		chien_idle,
		chien_search
	} chien_state_e;

endpackage

`default_nettype wire

/* source/bch_syndrome.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_syndrome
	import gf_pkg::*, bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_valid,
	input wire logic in_first,
	input wire logic in_bit,
	output logic syn_valid,
	output logic [bch_syn_cnt-1:0][gf_m-1:0] syn,
	output logic [bch_n-1:0] rx_word
);

	logic [3:0] cnt; // bits taken so far in the word
	logic last_bit;

	assign last_bit = in_valid && !in_first && (cnt == 4'(bch_n - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= last_bit; // one cycle after the fifteenth bit
			if (in_valid) begin
				if (in_first)
					cnt <= 4'd1;
				else if (last_bit)
					cnt <= '0;
				else
					cnt <= cnt + 4'd1;
			end
		end
	end

	// Horner step per syndrome: S_j = S_j * alpha^j + r_i
	always_ff @(posedge clk) begin
		if (in_valid) begin
			rx_word <= {rx_word[bch_n-2:0], in_bit}; // first bit ends up in the msb
			for (int j = 0; j < bch_syn_cnt; j++) begin
				if (in_first)
					syn[j] <= {{(gf_m-1){1'b0}}, in_bit};
				else
					syn[j] <= gf_mul(syn[j], gf_alpha_pow(j + 1)) ^ {{(gf_m-1){1'b0}}, in_bit};
			end
		end
	end

	// a word once started must arrive without gaps
	assert property (@(posedge clk) disable iff (!arst_n)
		(cnt != 4'd0) |-> in_valid)
		else $error("bch_syndrome: gap inside a codeword");

endmodule

`default_nettype wire

/* source/bch_key_solver.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_key_solver
	import gf_pkg::*, bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic syn_valid,
	input wire logic [bch_syn_cnt-1:0][gf_m-1:0] syn,
	input wire logic [bch_n-1:0] rx_word,
	output logic solved,
	output logic [bch_t:0][gf_m-1:0] sigma,
	output logic [bch_n-1:0] word
);

	solver_state_e state;
	logic [1:0] iter; // iteration number
	logic [bch_t:0][gf_m-1:0] beta;
	logic [bch_t:0][gf_m-1:0] dr_beta; // discrepancy times beta
	logic [bch_t:0][gf_m-1:0] dr_beta_next;
	logic [bch_t:0][gf_m-1:0] dp_sigma;
	logic [bch_syn_cnt-1:0][gf_m-1:0] win; // syndrome window with S_(2k+1-i) at win[2+i]
	logic [gf_m-1:0] d_r; // current discrepancy
	logic [gf_m-1:0] d_p; // previous discrepancy
	logic [gf_m-1:0] d_next;
	logic [2:0] l_reg; // locator length
	logic [2:0] l_next; // length after a change
	logic bsel;
	logic real_pass;
	logic s1_nz;

	assign s1_nz = (syn[0] != '0);

	// the load already consumed S1 so only two odd syndromes are left
	assign real_pass = (iter != 2'(bch_t - 1));

	always_comb begin
		d_next = '0;
		for (int i = 0; i <= bch_t; i++)
			d_next = d_next ^ gf_mul(sigma[i], win[2+i]);
		for (int i = 0; i <= bch_t; i++) begin
			dr_beta_next[i] = gf_mul(d_next, beta[i]);
			dp_sigma[i] = gf_mul(d_p, sigma[i]);
		end
	end

	// length change allowed when 2L <= 2k
	assign bsel = (d_r != '0) && (l_reg <= 3'(iter) + 3'd1);
	assign l_next = 3'(2 * iter + 3) - l_reg;

	assign solved = (state == solver_update) && !real_pass;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= solver_idle;
			iter <= '0;
		end else begin
			case (state)
				solver_idle: begin
					if (syn_valid) begin
						state <= solver_disc;
						iter <= '0;
					end
				end
				solver_disc: state <= solver_update;
				solver_update: begin
					if (real_pass) begin
						state <= solver_disc;
						iter <= iter + 2'd1;
					end else begin
						state <= solver_idle;
					end
				end
				default: state <= solver_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == solver_idle && syn_valid) begin
			word <= rx_word;
			sigma <= '0;
			sigma[0] <= 1; // 1 + S1 x
			sigma[1] <= syn[0];
			beta <= '0;
			if (s1_nz)
				beta[2] <= 1; // x^2
			else
				beta[3] <= 1; // x^3
			d_r <= s1_nz ? syn[0] : gf_m'(1);
			d_p <= s1_nz ? syn[0] : gf_m'(1);
			l_reg <= s1_nz ? 3'd1 : 3'd0;
			win <= '0;
			win[2] <= syn[2]; // S3
			win[3] <= syn[1];
			win[4] <= syn[0];
			win[1] <= syn[3];
			win[0] <= syn[4]; // S5
		end else if (state == solver_disc && real_pass) begin
			d_r <= d_next;
			dr_beta <= dr_beta_next;
		end else if (state == solver_update && real_pass) begin
			if (bsel && l_next > 3'(bch_t)) begin
				sigma <= '0; // locator longer than t
				sigma[bch_t] <= 1; // x^t has no nonzero root so the search fails the word
			end else begin
				for (int i = 0; i <= bch_t; i++)
					sigma[i] <= dp_sigma[i] ^ dr_beta[i];
			end
			beta[1:0] <= '0;
			beta[3:2] <= bsel ? sigma[1:0] : beta[1:0]; // times x^2
			if (bsel) begin
				d_p <= d_r;
				l_reg <= l_next;
			end
			for (int i = 2; i < bch_syn_cnt; i++)
				win[i] <= win[i-2];
			win[1:0] <= '0;
		end
	end

	// a new syndrome set must find the solver free
	assert property (@(posedge clk) disable iff (!arst_n)
		syn_valid |-> state == solver_idle)
		else $error("bch_key_solver: syndromes arrived while busy");

endmodule

`default_nettype wire

/* source/bch_chien_correct.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_chien_correct
	import gf_pkg::*, bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic solved,
	input wire logic [bch_t:0][gf_m-1:0] sigma,
	input wire logic [bch_n-1:0] word,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	output logic out_fail
);

	chien_state_e state;
	logic [3:0] pos; // code position, counts down
	logic [2:0] roots;
	logic [2:0] deg;
	logic [2:0] deg_next;
	logic [bch_t:0][gf_m-1:0] term;
	logic [bch_n-1:0] word_q;
	logic [gf_m-1:0] sum;
	logic root;

	always_comb begin
		deg_next = '0;
		for (int j = 1; j <= bch_t; j++)
			if (sigma[j] != '0)
				deg_next = 3'(j); // highest nonzero coefficient
		sum = '0;
		for (int j = 0; j <= bch_t; j++)
			sum = sum ^ term[j];
	end

	assign root = (sum == '0);
	assign out_valid = (state == chien_search);
	assign out_bit = word_q[pos] ^ root; // flip where sigma vanishes
	assign out_last = out_valid && (pos == 4'd0);
	assign out_fail = out_last && ((roots + 3'(root)) != deg);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= chien_idle;
			pos <= '0;
			roots <= '0;
		end else begin
			if (solved) begin
				state <= chien_search;
				pos <= 4'(bch_n - 1);
				roots <= '0;
			end else if (state == chien_search) begin
				roots <= roots + 3'(root);
				pos <= pos - 4'd1;
				if (pos == 4'd0)
					state <= chien_idle;
			end
		end
	end

	// term j steps by alpha^j, first visit is alpha^1 for position 14
	always_ff @(posedge clk) begin
		if (solved) begin
			word_q <= word;
			deg <= deg_next;
			for (int j = 0; j <= bch_t; j++)
				term[j] <= gf_mul(sigma[j], gf_alpha_pow(j));
		end else if (state == chien_search) begin
			for (int j = 0; j <= bch_t; j++)
				term[j] <= gf_mul(term[j], gf_alpha_pow(j));
		end
	end

	// next word only on the last search cycle or when idle
	assert property (@(posedge clk) disable iff (!arst_n)
		solved |-> (state == chien_idle) || (pos == 4'd0))
		else $error("bch_chien_correct: solved while search busy");

	assert property (@(posedge clk) disable iff (!arst_n)
		solved |=> out_valid [*15])
		else $error("bch_chien_correct: output word shorter than 15 bits");

endmodule

`default_nettype wire

/* source/bch_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_decoder
	import gf_pkg::*, bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_valid,
	input wire logic in_first,
	input wire logic in_bit,
	output logic out_valid,
	output logic out_bit,
	output logic out_last,
	output logic out_fail
);

	logic syn_valid;
	logic [bch_syn_cnt-1:0][gf_m-1:0] syn;
	logic [bch_n-1:0] rx_word;
	logic solved;
	logic [bch_t:0][gf_m-1:0] sigma;
	logic [bch_n-1:0] word;

	bch_syndrome bch_syndrome_inst (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_bit(in_bit),
		.syn_valid(syn_valid),
		.syn(syn),
		.rx_word(rx_word)
	);

	bch_key_solver bch_key_solver_inst (
		.clk(clk),
		.arst_n(arst_n),
		.syn_valid(syn_valid),
		.syn(syn),
		.rx_word(rx_word),
		.solved(solved),
		.sigma(sigma),
		.word(word)
	);

	bch_chien_correct bch_chien_correct_inst (
		.clk(clk),
		.arst_n(arst_n),
		.solved(solved),
		.sigma(sigma),
		.word(word),
		.out_valid(out_valid),
		.out_bit(out_bit),
		.out_last(out_last),
		.out_fail(out_fail)
	);

endmodule

`default_nettype wire

/* tb/bch_decoder_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_tb
	import bch_pkg::*;
();

	localparam logic [10:0] gen_poly = 11'h537; // x^10+x^8+x^5+x^4+x^2+x+1
	localparam int spaced_words = 24; // four per error count 0..5
	localparam int packed_words = 20;
	localparam int n_words = spaced_words + packed_words;

	logic clk;
	logic arst_n;
	logic in_valid;
	logic in_first;
	logic in_bit;
	logic out_valid;
	logic out_bit;
	logic out_last;
	logic out_fail;

	int seed = 32;
	int value_errors = 0;
	int frame_errors = 0;
	int pushed = 0;
	int popped;
	logic input_seen = 1'b0;

	logic [bch_n-1:0] sent_q[$];
	logic [bch_n-1:0] recv_q[$];
	int errs_q[$];
	string name_q[$];

	logic [bch_n-1:0] shift; // collector shift register
	logic [bch_n-1:0] got_full;
	logic got_fail;
	logic check_now;
	int bit_cnt;
	logic [bch_n-1:0] exp_sent;
	logic [bch_n-1:0] exp_recv;
	int exp_errs;
	string exp_name;
	logic got_is_code;
	int got_dist;

	bch_decoder bch_decoder_inst (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_bit(in_bit),
		.out_valid(out_valid),
		.out_bit(out_bit),
		.out_last(out_last),
		.out_fail(out_fail)
	);

	// remainder modulo the generator, bit i is the coefficient of x^i
	function automatic logic [bch_n-1:0] poly_rem(input logic [bch_n-1:0] v);
		logic [bch_n-1:0] r;
		r = v;
		for (int i = bch_n - 1; i >= 10; i--)
			if (r[i])
				r = r ^ (15'(gen_poly) << (i - 10));
		return r;
	endfunction

	function automatic logic [bch_n-1:0] encode(input logic [4:0] msg);
		logic [bch_n-1:0] shifted;
		shifted = {msg, 10'b0}; // systematic, message on top
		return shifted ^ poly_rem(shifted);
	endfunction

	function automatic string err_name(input int nerr);
		case (nerr)
			0: return "clean";
			1: return "one_err";
			2: return "two_err";
			3: return "three_err";
			4: return "four_err";
			default: return "five_err";
		endcase
	endfunction

	task automatic send_word(input string name, input int nerr, input int gap);
		logic [bch_n-1:0] code;
		logic [bch_n-1:0] mask;
		logic [bch_n-1:0] rx;
		int p;
		code = encode(5'($random(seed)));
		mask = '0;
		while ($countones(mask) != nerr) begin
			p = int'($unsigned($random(seed)) % bch_n); // distinct positions
			mask[p] = 1'b1;
		end
		rx = code ^ mask;
		sent_q.push_back(code);
		recv_q.push_back(rx);
		errs_q.push_back(nerr);
		name_q.push_back(name);
		pushed++;
		for (int i = bch_n - 1; i >= 0; i--) begin
			@(posedge clk);
			#1;
			input_seen = 1'b1;
			in_valid = 1'b1;
			in_first = (i == bch_n - 1);
			in_bit = rx[i]; // highest degree first
		end
		if (gap > 0) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			in_first = 1'b0;
			repeat (gap - 1) @(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// rebuild each returned word from the output strobes
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shift <= '0;
			bit_cnt <= 0;
			check_now <= 1'b0;
			popped <= 0;
		end else begin
			check_now <= 1'b0;
			if (out_valid) begin
				shift <= {shift[bch_n-2:0], out_bit};
				bit_cnt <= bit_cnt + 1;
				if (out_last) begin
					got_full <= {shift[bch_n-2:0], out_bit};
					got_fail <= out_fail;
					bit_cnt <= 0;
					check_now <= 1'b1;
					popped <= popped + 1;
					if (sent_q.size() > 0) begin
						exp_sent <= sent_q.pop_front();
						exp_recv <= recv_q.pop_front();
						exp_errs <= errs_q.pop_front();
						exp_name <= name_q.pop_front();
					end
				end
			end
		end
	end

	assign got_is_code = (poly_rem(got_full) == '0);
	assign got_dist = $countones(got_full ^ exp_recv);

	assert property (@(posedge clk) disable iff (!arst_n)
		check_now && (exp_errs <= bch_t) |-> got_full == exp_sent)
		else begin
			value_errors++;
			$display("Error: %s expected %h actual %h", exp_name, exp_sent, got_full);
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		check_now && (exp_errs <= bch_t) |-> !got_fail)
		else begin
			value_errors++;
			$display("Error: %s out_fail expected 0 actual %b", exp_name, got_fail);
		end

	// beyond t: either flagged or a codeword close to what was received
	assert property (@(posedge clk) disable iff (!arst_n)
		check_now && (exp_errs > bch_t) |-> got_fail || (got_is_code && got_dist <= bch_t))
		else begin
			value_errors++;
			$display("Error: %s expected fail or codeword near %h actual %h fail %b",
				exp_name, exp_recv, got_full, got_fail);
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		!input_seen |-> !out_valid && !out_last && !out_fail)
		else begin
			frame_errors++;
			$display("Error: output active after reset before any input");
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		out_last |-> out_valid && bit_cnt == bch_n - 1)
		else begin
			frame_errors++;
			$display("Error: out_last did not fall on the fifteenth output bit");
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && bit_cnt == bch_n - 1 |-> out_last)
		else begin
			frame_errors++;
			$display("Error: output word ran past fifteen bits");
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		bit_cnt != 0 |-> out_valid)
		else begin
			frame_errors++;
			$display("Error: out_valid dropped inside an output word");
		end

	assert property (@(posedge clk) disable iff (!arst_n)
		out_last |-> popped < pushed)
		else begin
			frame_errors++;
			$display("Error: output word returned with nothing sent");
		end

	initial begin
		repeat (n_words * bch_n + 200) @(posedge clk);
		$display("Error: watchdog expired with %0d of %0d words returned", popped, n_words);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_bit = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		repeat (12) @(posedge clk); // outputs must stay quiet here
		for (int e = 0; e <= 5; e++)
			for (int k = 0; k < spaced_words / 6; k++)
				send_word(err_name(e), e, 3);
		for (int k = 0; k < packed_words; k++)
			send_word("back_to_back", int'($unsigned($random(seed)) % 4), 0); // no gap
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_first = 1'b0;
		wait (popped == n_words);
		repeat (4) @(posedge clk);
		$display("errors: %0d value, %0d framing", value_errors, frame_errors);
		if (value_errors + frame_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
source/gf_pkg.sv
source/bch_pkg.sv
source/bch_syndrome.sv
source/bch_key_solver.sv
source/bch_chien_correct.sv
source/bch_decoder.sv
tb/bch_decoder_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := bch_decoder_tb
FILELIST := files.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
